// ==== build.f ====
cdb_pkg.sv
prio_enc.sv
cdb_arbiter.sv
cdb_mux.sv
cdb_out_reg.sv
cdb_top.sv
tb_cdb_top.sv

// ==== Makefile ====
# Verilator build for the CDB writeback path testbench

VERILATOR ?= verilator
TOP       ?= tb_cdb_top
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert
PASS_MSG  := Simulation finished: PASS

SIM := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(shell cat $(FILELIST))
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	@out=$$(./$(SIM)); \
	echo "$$out"; \
	if echo "$$out" | grep -q "$(PASS_MSG)"; then \
		exit 0; \
	else \
		echo "Pass message not found"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR)

// ==== tb_cdb_top.sv ====
// Directed testbench for the CDB writeback path
// Inputs change on the rising edge, outputs are checked on the falling edge
// A small reference model tracks the batch and the results expected at the ROB
`timescale 1ns/1ps

module tb_cdb_top
    import cdb_pkg::*;
;

    localparam int RAND_CYCLES = 200;
    localparam int DRAIN_MAX = 40;
    // Run bound in cycles from the random run and eight drains at their limit
    localparam int RUN_CYCLES = RAND_CYCLES + 8 * DRAIN_MAX;

    logic                          clk_i;
    logic                          rst_n_i;
    logic                          flush_i;
    logic                          max_prio_valid_i;
    logic [ROB_IDX_W-1:0]          max_prio_rob_idx_i;
    logic                          max_prio_except_i;
    cdb_word_u                     max_prio_word_i;
    logic                          max_prio_ready_o;
    logic [EU_N-2:0]               valid_i;
    logic [(EU_N-1)*ROB_IDX_W-1:0] rob_idx_i;
    logic [EU_N-2:0]               except_i;
    logic [(EU_N-1)*XLEN-1:0]      word_i;
    logic [EU_N-2:0]               ready_o;
    logic                          rob_valid_o;
    logic [ROB_IDX_W-1:0]          rob_idx_o;
    logic                          rob_except_o;
    cdb_word_u                     rob_word_o;
    logic                          rob_ready_i;

    // Unit side state with index 0 for the maximum-priority unit
    logic                 req [0:EU_N-1];
    logic [ROB_IDX_W-1:0] p_idx [0:EU_N-1];
    logic                 p_exc [0:EU_N-1];
    cdb_word_u            p_word [0:EU_N-1];
    logic                 rob_rdy;
    logic                 flush_r;

    // Reference model state
    logic [EU_N-2:0]      pend;
    logic [ROB_IDX_W-1:0] exp_idx [$];
    logic                 exp_exc [$];
    logic [XLEN-1:0]      exp_word [$];
    logic [ROB_IDX_W-1:0] deliv_idx [$];
    int                   seed;

    // Snapshot of stalled ROB outputs
    logic                 held;
    logic [ROB_IDX_W-1:0] held_idx;
    logic                 held_exc;
    logic [XLEN-1:0]      held_word;

    cdb_top cdb_top_inst (.*);

    initial begin
        clk_i = 1'b0;
        forever #4 clk_i = ~clk_i;
    end

    // Watchdog
    initial begin
        #((RUN_CYCLES + 100) * 8);
        $display("Simulation finished: FAIL");
        $fatal(1, "Watchdog expired before the tests completed");
    end

    task automatic stop_on_error();
        $display("Simulation finished: FAIL");
        $fatal(1, "Stopped at first error");
    endtask

    task automatic check_hex(input string name, input logic [31:0] got, input logic [31:0] exp);
        assert (got == exp) else begin
            $display("Fail %s got %h expected %h at %0t", name, got, exp, $time);
            stop_on_error();
        end
    endtask

    task automatic set_req(input int u, input logic [ROB_IDX_W-1:0] idx, input logic exc);
        int rnd;
        rnd = $random(seed);
        req[u] = 1'b1;
        p_idx[u] = idx;
        p_exc[u] = exc;
        p_word[u].value = rnd;
        // Exception codes carry a clear pad
        if (exc) begin
            p_word[u].exc.pad = '0;
        end
    endtask

    // Apply the unit and ROB state to the DUT inputs
    task automatic drive();
        logic [EU_N-2:0]               v;
        logic [(EU_N-1)*ROB_IDX_W-1:0] iv;
        logic [EU_N-2:0]               ev;
        logic [(EU_N-1)*XLEN-1:0]      wv;
        for (int k = 1; k < EU_N; k++) begin
            v[k-1] = req[k];
            iv[(k-1)*ROB_IDX_W +: ROB_IDX_W] = p_idx[k];
            ev[k-1] = p_exc[k];
            wv[(k-1)*XLEN +: XLEN] = p_word[k].value;
        end
        max_prio_valid_i   <= req[0];
        max_prio_rob_idx_i <= p_idx[0];
        max_prio_except_i  <= p_exc[0];
        max_prio_word_i    <= p_word[0];
        valid_i            <= v;
        rob_idx_i          <= iv;
        except_i           <= ev;
        word_i             <= wv;
        rob_ready_i        <= rob_rdy;
        flush_i            <= flush_r;
    endtask

    // One clock with drive on the rising edge and checks on the falling edge
    task automatic cycle();
        int              win;
        logic            stage_ok;
        logic [EU_N-2:0] cand;
        logic [EU_N-2:0] exp_rdy;
        @(posedge clk_i);
        drive();
        @(negedge clk_i);
        // Stage is free when the model holds nothing or the ROB takes the entry now
        stage_ok = (exp_idx.size() == 0) || rob_rdy;
        // A result accepted at the last edge must be on the ROB side now
        check_hex("rob_valid_o", 32'(rob_valid_o), 32'(exp_idx.size() > 0));
        if (held) begin
            check_hex("stalled rob_idx_o", 32'(rob_idx_o), 32'(held_idx));
            check_hex("stalled rob_except_o", 32'(rob_except_o), 32'(held_exc));
            check_hex("stalled rob_word_o", rob_word_o.value, held_word);
        end
        held = 1'b0;
        if (exp_idx.size() > 0) begin
            check_hex("rob_idx_o", 32'(rob_idx_o), 32'(exp_idx[0]));
            check_hex("rob_except_o", 32'(rob_except_o), 32'(exp_exc[0]));
            if (exp_exc[0]) begin
                check_hex("rob_word_o.exc.code", 32'(rob_word_o.exc.code),
                          32'(exp_word[0][EXCEPT_W-1:0]));
            end else begin
                check_hex("rob_word_o.value", rob_word_o.value, exp_word[0]);
            end
            if (rob_rdy) begin
                deliv_idx.push_back(rob_idx_o);
                void'(exp_idx.pop_front());
                void'(exp_exc.pop_front());
                void'(exp_word.pop_front());
            end else begin
                held = 1'b1;
                held_idx = rob_idx_o;
                held_exc = rob_except_o;
                held_word = rob_word_o.value;
            end
        end
        // Expected winner from the batch rule
        win = -1;
        cand = (|pend) ? pend : {req[4], req[3], req[2], req[1]};
        if (!flush_r) begin
            if (req[0]) begin
                win = 0;
            end else begin
                for (int k = EU_N - 2; k >= 0; k--) begin
                    if (cand[k]) win = k + 1;
                end
            end
        end
        exp_rdy = '0;
        if (win > 0 && stage_ok) exp_rdy[win-1] = 1'b1;
        check_hex("max_prio_ready_o", 32'(max_prio_ready_o), 32'(win == 0 && stage_ok));
        check_hex("ready_o", 32'(ready_o), 32'(exp_rdy));
        if (flush_r) begin
            // Stage content and batch are dropped
            pend = '0;
            held = 1'b0;
            exp_idx.delete();
            exp_exc.delete();
            exp_word.delete();
        end else if (win >= 0 && stage_ok) begin
            exp_idx.push_back(p_idx[win]);
            exp_exc.push_back(p_exc[win]);
            exp_word.push_back(p_word[win].value);
            req[win] = 1'b0;
            if (win > 0) begin
                cand[win-1] = 1'b0;
                pend = cand;
            end
        end
    endtask

    task automatic drain();
        int n;
        logic busy;
        rob_rdy = 1'b1;
        n = 0;
        busy = 1'b1;
        while (busy) begin
            cycle();
            n++;
            busy = (exp_idx.size() > 0);
            for (int u = 0; u < EU_N; u++) busy = busy || req[u];
            assert (n < DRAIN_MAX) else begin
                $display("Results did not drain within %0d cycles", DRAIN_MAX);
                stop_on_error();
            end
        end
        // One more cycle to see the path idle
        cycle();
    endtask

    task automatic check_order(input logic [ROB_IDX_W-1:0] order [$]);
        check_hex("delivered count", 32'(deliv_idx.size()), 32'(order.size()));
        foreach (order[i]) begin
            check_hex("delivered rob_idx", 32'(deliv_idx[i]), 32'(order[i]));
        end
    endtask

    task automatic test_reset_idle();
        repeat (4) cycle();
        check_hex("rob_valid_o", 32'(rob_valid_o), 32'h0);
    endtask

    task automatic test_single_unit();
        deliv_idx.delete();
        set_req(2, 4'h6, 1'b0);
        drain();
        set_req(3, 4'hb, 1'b1);
        drain();
        check_order('{4'h6, 4'hb});
    endtask

    task automatic test_batch_order();
        deliv_idx.delete();
        for (int u = 1; u < EU_N; u++) set_req(u, 4'(u), 1'b0);
        cycle();
        // Unit 1 asks again at once and must wait for the batch
        set_req(1, 4'h5, 1'b0);
        drain();
        check_order('{4'h1, 4'h2, 4'h3, 4'h4, 4'h5});
    endtask

    task automatic test_max_prio_preempt();
        deliv_idx.delete();
        for (int u = 1; u < EU_N; u++) set_req(u, 4'(u), 1'b0);
        cycle();
        cycle();
        set_req(0, 4'h9, 1'b1);
        drain();
        check_order('{4'h1, 4'h2, 4'h9, 4'h3, 4'h4});
    endtask

    task automatic test_random_stall();
        int rnd;
        int issued;
        issued = 0;
        deliv_idx.delete();
        for (int c = 0; c < RAND_CYCLES; c++) begin
            rnd = $random(seed);
            rob_rdy = rnd[0];
            for (int u = 0; u < EU_N; u++) begin
                rnd = $random(seed);
                if (!req[u] && rnd[2:0] == 3'd0) begin
                    set_req(u, 4'(issued), rnd[3]);
                    issued++;
                end
            end
            cycle();
        end
        drain();
    endtask

    task automatic test_flush();
        deliv_idx.delete();
        for (int u = 1; u < EU_N; u++) set_req(u, 4'(u), 1'b0);
        cycle();
        cycle();
        // Units abandon their requests with the flush
        flush_r = 1'b1;
        for (int u = 0; u < EU_N; u++) req[u] = 1'b0;
        cycle();
        flush_r = 1'b0;
        cycle();
        check_hex("rob_valid_o after flush", 32'(rob_valid_o), 32'h0);
        deliv_idx.delete();
        set_req(4, 4'hc, 1'b0);
        set_req(2, 4'hd, 1'b0);
        drain();
        check_order('{4'hd, 4'hc});
    endtask

    initial begin
        seed = 32'hd6f8_7cb5;
        for (int u = 0; u < EU_N; u++) begin
            req[u] = 1'b0;
            p_idx[u] = '0;
            p_exc[u] = 1'b0;
            p_word[u].value = '0;
        end
        pend = '0;
        held = 1'b0;
        rob_rdy = 1'b0;
        flush_r = 1'b0;
        rst_n_i = 1'b0;
        flush_i = 1'b0;
        max_prio_valid_i = 1'b0;
        max_prio_rob_idx_i = '0;
        max_prio_except_i = 1'b0;
        max_prio_word_i = '0;
        valid_i = '0;
        rob_idx_i = '0;
        except_i = '0;
        word_i = '0;
        rob_ready_i = 1'b0;
        repeat (3) @(posedge clk_i);
        rst_n_i <= 1'b1;
        test_reset_idle();
        test_single_unit();
        test_batch_order();
        test_max_prio_preempt();
        test_random_stall();
        test_flush();
        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

// ==== cdb_top.sv ====
// CDB writeback path, arbiter plus mux plus registered output stage
// One cycle from an accepted unit transfer to rob_valid_o
// Ordinary unit k uses bit k-1 of valid_i and ready_o and slot k-1 of the buses
`timescale 1ns/1ps

module cdb_top
    import cdb_pkg::*;
(
    input  logic                          clk_i,
    input  logic                          rst_n_i,
    input  logic                          flush_i,

    // Maximum-priority unit
    input  logic                          max_prio_valid_i,
    input  logic [ROB_IDX_W-1:0]          max_prio_rob_idx_i,
    input  logic                          max_prio_except_i,
    input  cdb_word_u                     max_prio_word_i,
    output logic                          max_prio_ready_o,

    // Ordinary units
    input  logic [EU_N-2:0]               valid_i,
    input  logic [(EU_N-1)*ROB_IDX_W-1:0] rob_idx_i,
    input  logic [EU_N-2:0]               except_i,
    input  logic [(EU_N-1)*XLEN-1:0]      word_i,
    output logic [EU_N-2:0]               ready_o,

    // ROB side
    output logic                          rob_valid_o,
    output logic [ROB_IDX_W-1:0]          rob_idx_o,
    output logic                          rob_except_o,
    output cdb_word_u                     rob_word_o,
    input  logic                          rob_ready_i
);

    // Arbiter selection
    logic                 grant_valid;
    logic                 served_max_prio;
    logic [EU_IDX_W-1:0]  served;

    // Stage back-pressure toward the arbiter
    logic                 stage_ready;

    // Routed payload
    logic [ROB_IDX_W-1:0] sel_rob_idx;
    logic                 sel_except;
    cdb_word_u            sel_word;

    cdb_arbiter cdb_arbiter_inst (
        .clk_i             (clk_i),
        .rst_n_i           (rst_n_i),
        .flush_i           (flush_i),
        .max_prio_valid_i  (max_prio_valid_i),
        .max_prio_ready_o  (max_prio_ready_o),
        .valid_i           (valid_i),
        .ready_o           (ready_o),
        .stage_ready_i     (stage_ready),
        .grant_valid_o     (grant_valid),
        .served_max_prio_o (served_max_prio),
        .served_o          (served)
    );

    cdb_mux cdb_mux_inst (
        .max_prio_rob_idx_i (max_prio_rob_idx_i),
        .max_prio_except_i  (max_prio_except_i),
        .max_prio_word_i    (max_prio_word_i),
        .rob_idx_i          (rob_idx_i),
        .except_i           (except_i),
        .word_i             (word_i),
        .served_max_prio_i  (served_max_prio),
        .served_i           (served),
        .sel_rob_idx_o      (sel_rob_idx),
        .sel_except_o       (sel_except),
        .sel_word_o         (sel_word)
    );

    cdb_out_reg cdb_out_reg_inst (
        .clk_i         (clk_i),
        .rst_n_i       (rst_n_i),
        .flush_i       (flush_i),
        .in_valid_i    (grant_valid),
        .in_rob_idx_i  (sel_rob_idx),
        .in_except_i   (sel_except),
        .in_word_i     (sel_word),
        .stage_ready_o (stage_ready),
        .rob_valid_o   (rob_valid_o),
        .rob_idx_o     (rob_idx_o),
        .rob_except_o  (rob_except_o),
        .rob_word_o    (rob_word_o),
        .rob_ready_i   (rob_ready_i)
    );

endmodule

// ==== cdb_out_reg.sv ====
// Single-entry output stage toward the ROB
// stage_ready_o passes rob_ready_i through when full, so one result per cycle
// Content is held stable while the ROB stalls
`timescale 1ns/1ps

module cdb_out_reg
    import cdb_pkg::*;
(
    input  logic                 clk_i,
    input  logic                 rst_n_i,
    input  logic                 flush_i,

    // From the arbiter and the mux
    input  logic                 in_valid_i,
    input  logic [ROB_IDX_W-1:0] in_rob_idx_i,
    input  logic                 in_except_i,
    input  cdb_word_u            in_word_i,
    output logic                 stage_ready_o,

    // Toward the ROB
    output logic                 rob_valid_o,
    output logic [ROB_IDX_W-1:0] rob_idx_o,
    output logic                 rob_except_o,
    output cdb_word_u            rob_word_o,
    input  logic                 rob_ready_i
);

    // Entry holds a result not yet taken by the ROB
    logic                 full_q;

    // Entry content
    logic [ROB_IDX_W-1:0] idx_q;
    logic                 except_q;
    cdb_word_u            word_q;

    // New result written this cycle
    logic                 load;

    // Empty, or the ROB drains the entry in this same cycle
    assign stage_ready_o = !full_q || rob_ready_i;

    assign load = in_valid_i && stage_ready_o && !flush_i;

    // Full flag
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            full_q <= 1'b0;
        end else if (flush_i) begin
            // Drop whatever the stage holds
            full_q <= 1'b0;
        end else if (load) begin
            full_q <= 1'b1;
        end else if (rob_ready_i) begin
            full_q <= 1'b0;
        end
    end

    // Payload
    always_ff @(posedge clk_i) begin
        if (load) begin
            idx_q    <= in_rob_idx_i;
            except_q <= in_except_i;
            word_q   <= in_word_i;
        end
    end

    assign rob_valid_o  = full_q;
    assign rob_idx_o    = idx_q;
    assign rob_except_o = except_q;
    assign rob_word_o   = word_q;

endmodule

// ==== cdb_mux.sv ====
// CDB payload multiplexer
// Unit k (1 to EU_N-1) owns slot k-1 of each flattened bus
// An out-of-range served index routes zeros
`timescale 1ns/1ps

module cdb_mux
    import cdb_pkg::*;
(
    // Maximum-priority unit payload
    input  logic [ROB_IDX_W-1:0]          max_prio_rob_idx_i,
    input  logic                          max_prio_except_i,
    input  cdb_word_u                     max_prio_word_i,

    // Ordinary unit payloads, flattened by slot
    input  logic [(EU_N-1)*ROB_IDX_W-1:0] rob_idx_i,
    input  logic [EU_N-2:0]               except_i,
    input  logic [(EU_N-1)*XLEN-1:0]      word_i,

    // Selection from the arbiter
    input  logic                          served_max_prio_i,
    input  logic [EU_IDX_W-1:0]           served_i,

    // Payload toward the output stage
    output logic [ROB_IDX_W-1:0]          sel_rob_idx_o,
    output logic                          sel_except_o,
    output cdb_word_u                     sel_word_o
);

    always_comb begin
        sel_rob_idx_o    = '0;
        sel_except_o     = 1'b0;
        sel_word_o.value = '0;
        if (served_max_prio_i) begin
            // Maximum-priority unit overrides any ordinary selection
            sel_rob_idx_o = max_prio_rob_idx_i;
            sel_except_o  = max_prio_except_i;
            sel_word_o    = max_prio_word_i;
        end else begin
            // Slot lookup by compare, no wide shifter
            for (int k = 0; k < EU_N - 1; k++) begin
                if (served_i == EU_IDX_W'(k)) begin
                    sel_rob_idx_o    = rob_idx_i[k*ROB_IDX_W +: ROB_IDX_W];
                    sel_except_o     = except_i[k];
                    sel_word_o.value = word_i[k*XLEN +: XLEN];
                end
            end
        end
    end

endmodule

// ==== cdb_arbiter.sv ====
// Batch-fair CDB arbiter with one pre-empting maximum-priority unit
// Units must hold valid until their transfer, a batch entry is never dropped
// served_o indexes the ordinary units from 0, so bit k-1 of valid_i is unit k
`timescale 1ns/1ps

module cdb_arbiter
    import cdb_pkg::*;
(
    input  logic                clk_i,
    input  logic                rst_n_i,
    input  logic                flush_i,

    // Maximum-priority unit handshake
    input  logic                max_prio_valid_i,
    output logic                max_prio_ready_o,

    // Ordinary unit handshakes
    input  logic [EU_N-2:0]     valid_i,
    output logic [EU_N-2:0]     ready_o,

    // Output stage can take a result this cycle
    input  logic                stage_ready_i,

    // Selection toward the mux and the output stage
    output logic                grant_valid_o,
    output logic                served_max_prio_o,
    output logic [EU_IDX_W-1:0] served_o
);

    // Requests still waiting from the current batch
    logic [EU_N-2:0]     pend_q;

    // Candidate set, either the batch or the live requests
    logic [EU_N-2:0]     cand;

    // Encoded and one-hot winner among the ordinary units
    logic [EU_IDX_W-1:0] enc;
    logic                enc_valid;
    logic [EU_N-2:0]     ord_grant;

    // A result moves into the output stage
    logic                accept;

    // New batch only once the old one is empty
    assign cand = (|pend_q) ? pend_q : valid_i;

    prio_enc #(
        .N (EU_N - 1)
    ) prio_enc_inst (
        .lines_i (cand),
        .enc_o   (enc),
        .valid_o (enc_valid)
    );

    // Back to one-hot for masking and for the ready lines
    always_comb begin
        ord_grant = '0;
        for (int k = 0; k < EU_N - 1; k++) begin
            if (enc_valid && (enc == EU_IDX_W'(k))) begin
                ord_grant[k] = 1'b1;
            end
        end
    end

    // Nothing is granted in a flush cycle
    assign grant_valid_o     = !flush_i && (max_prio_valid_i || enc_valid);
    assign served_max_prio_o = max_prio_valid_i;
    assign served_o          = enc;

    assign accept = grant_valid_o && stage_ready_i;

    // Maximum-priority unit waits for the stage like the others
    assign max_prio_ready_o = !flush_i && max_prio_valid_i && stage_ready_i;

    // Ordinary winner gets ready only when not pre-empted
    always_comb begin
        ready_o = '0;
        if (!flush_i && !max_prio_valid_i && stage_ready_i) begin
            ready_o = ord_grant;
        end
    end

    // Batch register
    // Updated only on an accepted ordinary transfer so a stalled grant stays pending
    // A maximum-priority transfer leaves the batch as it was
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            pend_q <= '0;
        end else if (flush_i) begin
            pend_q <= '0;
        end else if (accept && !max_prio_valid_i) begin
            pend_q <= cand & ~ord_grant;
        end
    end

endmodule

// ==== prio_enc.sv ====
// Priority encoder, the lowest set line wins
// N must not exceed 2**EU_IDX_W
// enc_o is zero when no line is set
`timescale 1ns/1ps

module prio_enc
    import cdb_pkg::*;
#(
    parameter int N = EU_N - 1
) (
    input  logic [N-1:0]        lines_i,
    output logic [EU_IDX_W-1:0] enc_o,
    output logic                valid_o
);

    always_comb begin
        enc_o   = '0;
        valid_o = 1'b0;
        // Scan from the top so the lowest set line is written last
        for (int i = N - 1; i >= 0; i--) begin
            if (lines_i[i]) begin
                enc_o   = EU_IDX_W'(i);
                valid_o = 1'b1;
            end
        end
    end

endmodule

// ==== cdb_pkg.sv ====
// Shared constants and the result word type for the CDB writeback path
// Unit 0 is the maximum-priority unit, units 1 to EU_N-1 are ordinary units
// EU_IDX_W must be wide enough to index the ordinary units
package cdb_pkg;

    // Execution units on the bus, the maximum-priority unit included
    localparam int EU_N = 5;

    // Width of a served-unit index
    localparam int EU_IDX_W = 3;

    // Width of the result word
    localparam int XLEN = 32;

    // Width of a ROB entry index
    localparam int ROB_IDX_W = 4;

    // Width of an exception code
    localparam int EXCEPT_W = 6;

    // Exception view of the result word
    // Code sits in the low bits, the pad fills the rest
    typedef struct packed {
        logic [XLEN-EXCEPT_W-1:0] pad;
        logic [EXCEPT_W-1:0]      code;
    } cdb_except_t;

    // Result word as it travels on the bus
    // The exception flag beside the word picks the view
    // Flag low means value, flag high means exc
    typedef union packed {
        logic [XLEN-1:0] value;
        cdb_except_t     exc;
    } cdb_word_u;

endpackage
